//--- flist.f
+incdir+tests
common/mem_map_pkg.sv
common/mac_cfg_pkg.sv
design/reset_seq.sv
loader/rom_loader.sv
loader/floppy_detect.sv
memory/mem_arbiter.sv
design/disk_activity_led.sv
design/macplus_glue_top.sv
tests/tb_macplus_glue.sv

//--- tests/tb_ref_model.svh
// ========================================
// reference model: address maps, floppy
// detection, read data and memory fill
// ========================================
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// download byte address to sdram word, downloads start at word 0x200000
function automatic logic [24:0] ref_dl_addr(input logic [7:0] idx, input logic [24:0] byte_addr);
	logic [24:0] base;
	base = 25'h200000;
	// floppy slots sit 512k words apart
	if (idx[1:0] != 2'b00) begin
		return base + 25'(idx[1:0]) * 25'h80000 + 25'(byte_addr[19:1]);
	end
	// rom images sit 256k words apart, index bit 6 picks one
	return base + (idx[6] ? 25'h40000 : 25'h0) + 25'(byte_addr[18:1]);
endfunction

// rom reads land on the image of the latched model
function automatic logic [24:0] ref_rom_addr(input mac_model_t m, input logic [CS_AW-1:0] cs);
	return {ROM_REGION, 21'h0} + ((m == MODEL_SE) ? 25'h40000 : 25'h0) + 25'(cs[18:1]);
endfunction

// ram is a plain word window at the bottom
function automatic logic [24:0] ref_ram_addr(input logic [CS_AW-1:0] cs);
	return 25'(cs[21:1]);
endfunction

// disk images are byte wide, odd address is the low byte
function automatic logic [15:0] ref_disk_word(input logic [15:0] w, input logic odd);
	logic [7:0] b;
	b = odd ? w[7:0] : w[15:8];
	return {b, b};
endfunction

// byte enable merge of a chipset write
function automatic logic [15:0] ref_merge(input logic [15:0] old, input logic [15:0] d,
		input logic uds, input logic lds);
	return {uds ? d[15:8] : old[15:8], lds ? d[7:0] : old[7:0]};
endfunction

// {inserted, double_sided} from the final word count
function automatic logic [1:0] ref_floppy(input logic [23:0] words);
	logic ds;
	logic ss;
	ds = (words == 24'd409600);
	ss = (words == 24'd204800);
	return {ds | ss, ds};
endfunction

// power-on content, every address bit takes part
function automatic logic [15:0] ref_fill(input logic [24:0] a);
	return a[15:0] ^ {a[24:16], a[22:16]} ^ 16'h3c5a;
endfunction

`endif

//--- tests/tb_macplus_glue.sv
// ========================================
// testbench for the memory glue top level
// with sdram model and reference checks
// ========================================
module tb_macplus_glue
	import mem_map_pkg::*;
	import mac_cfg_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_HOLD = 16;
	localparam int SLOT_LEN   = 4;
	localparam int LED_HOLD   = 12;
	localparam int MEM_WORDS  = 1 << 22;
	// three slot rounds is more than any write can take
	localparam int WR_LIMIT   = 12 * SLOT_LEN;

	logic clk_sys, rst_n, reset_req, cpu_reset_n, ram_4mb_sel, sys_reset_n, ram_4mb;
	mac_model_t model_sel, model, exp_model;
	logic dl_active, dl_wr, dl_wait;
	dl_index_t dl_index;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [CS_AW-1:0] cs_addr;
	logic cs_rom_rd, cs_ram_rd, cs_ram_wr, cs_uds, cs_lds, cs_disk_rd;
	logic [SDRAM_DW-1:0] cs_wdata, cs_rdata, sdram_din, sdram_dout;
	logic [SDRAM_AW-1:0] sdram_addr;
	logic [1:0] sdram_ds, eject, floppy_ins, floppy_ds, disk_act, disk_motor;
	logic sdram_we, sdram_oe, led;
	logic [1:0] exp_ins, exp_ds;
	logic [15:0] mem [0:MEM_WORDS-1];
	integer seed;
	int checks, errors, timeouts, io_reads;

	`include "tb_ref_model.svh"

	macplus_glue_top #(
		.RESET_HOLD(RESET_HOLD),
		.SLOT_LEN  (SLOT_LEN),
		.LED_HOLD  (LED_HOLD)
	) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ========================================
	// sdram model
	// ========================================

	// combinational reads over the 22 address bits that are ever used
	assign sdram_dout = mem[sdram_addr[21:0]];

	always @(posedge clk_sys) begin
		if (sdram_we) begin
			if (sdram_addr[24:22] != 3'b000) begin
				$display("sdram write outside the modelled range at %h", sdram_addr);
				errors++;
			end
			if (sdram_ds[1])
				mem[sdram_addr[21:0]][15:8] <= sdram_din[15:8];
			if (sdram_ds[0])
				mem[sdram_addr[21:0]][7:0] <= sdram_din[7:0];
		end
	end

	function automatic logic [15:0] mem_read(input logic [SDRAM_AW-1:0] a);
		return mem[a[21:0]];
	endfunction

	// ========================================
	// compare tasks
	// ========================================

	task automatic check_word(input string name, input logic [SDRAM_DW-1:0] got,
			input logic [SDRAM_DW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [SDRAM_AW-1:0] got,
			input logic [SDRAM_AW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_model(input string name, input mac_model_t got, input mac_model_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	// ========================================
	// stimulus helpers
	// ========================================

	// drive point 2 ns after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	// fixed hold count and then the latched selections must stay put
	task automatic expect_release(input logic ram_sel, input mac_model_t mdl);
		for (int n = 1; n <= RESET_HOLD + 1; n++) begin
			step();
			if (n == RESET_HOLD)
				check_flag("sys_reset_n", sys_reset_n, 1'b0);
		end
		check_flag("sys_reset_n", sys_reset_n, 1'b1);
		check_flag("ram_4mb", ram_4mb, ram_sel);
		check_model("model", model, mdl);
		ram_4mb_sel = !ram_sel;
		model_sel   = mac_model_t'(!mdl);
		repeat (3) step();
		check_flag("ram_4mb", ram_4mb, ram_sel);
		check_model("model", model, mdl);
		ram_4mb_sel = ram_sel;
		model_sel   = mdl;
		exp_model   = mdl;
	endtask

	// chipset reads keep running and io slot reads must come back as all ones
	// the loader owns the port there, so no read strobe reaches the sdram
	task automatic wait_write_done();
		int n;
		n = 0;
		do begin
			step();
			cs_addr = CS_AW'($random(seed));
			@(negedge clk_sys);
			if (sdram_we) begin
				io_reads++;
				check_word("cs_rdata", cs_rdata, 16'hffff);
				check_flag("sdram_oe", sdram_oe, 1'b0);
			end
			n++;
		end while (dl_wait && n < WR_LIMIT);
		if (dl_wait) begin
			$display("timeout: dl_wait still high after %0d cycles", WR_LIMIT);
			timeouts++;
		end
	endtask

	task automatic send_word(input logic [24:0] a, input logic [15:0] d);
		step();
		dl_addr = a;
		dl_data = d;
		dl_wr   = 1'b1;
		step();
		dl_wr = 1'b0;
		check_flag("dl_wait", dl_wait, 1'b1);
		wait_write_done();
	endtask

	// last address seen at the fall gives the image size
	task automatic end_download(input logic [24:0] end_addr);
		step();
		dl_addr   = end_addr;
		dl_active = 1'b0;
		cs_ram_rd = 1'b0;
		step();
	endtask

	task automatic check_floppies();
		for (int d = 0; d < 2; d++) begin
			check_flag($sformatf("floppy_ins[%0d]", d), floppy_ins[d], exp_ins[d]);
			check_flag($sformatf("floppy_ds[%0d]", d), floppy_ds[d], exp_ds[d]);
		end
	endtask

	// ========================================
	// test groups
	// ========================================

	task automatic run_reset_tests();
		logic       r;
		mac_model_t m;
		for (int k = 0; k < 4; k++) begin
			r = 1'($random(seed));
			m = mac_model_t'(1'($random(seed)));
			step();
			reset_req   = 1'b1;
			ram_4mb_sel = r;
			model_sel   = m;
			step();
			step();
			check_flag("sys_reset_n", sys_reset_n, 1'b0);
			reset_req = 1'b0;
			expect_release(r, m);
		end
	endtask

	task automatic run_downloads();
		logic [7:0]  idx;
		logic [24:0] a;
		logic [15:0] d;
		for (int k = 0; k < 4; k++) begin
			// plus rom, se rom, internal floppy, external floppy
			case (k)
				0: idx = DL_ROM;
				1: idx = 8'h40;
				2: idx = DL_FLOPPY_INT;
				default: idx = DL_FLOPPY_EXT;
			endcase
			step();
			dl_index  = dl_index_t'(idx);
			dl_active = 1'b1;
			cs_ram_rd = 1'b1;
			for (int w = 0; w < 6; w++) begin
				a = 25'($random(seed)) & 25'h0ffffe;
				d = 16'($random(seed));
				send_word(a, d);
				check_word($sformatf("mem[%h]", ref_dl_addr(idx, a)),
					mem_read(ref_dl_addr(idx, a)), {d[7:0], d[15:8]});
			end
			// size zero leaves the drive empty
			end_download('0);
			if (k >= 2) begin
				exp_ins[k-2] = 1'b0;
				exp_ds[k-2]  = 1'b0;
			end
			check_floppies();
		end
		if (io_reads == 0) begin
			$display("no chipset read was seen during a download io slot");
			errors++;
		end
	endtask

	task automatic run_floppy_tests();
		logic [23:0] words;
		logic [1:0]  res;
		for (int d = 0; d < 2; d++) begin
			for (int k = 0; k < 3; k++) begin
				case (k)
					0: words = 24'($random(seed)) & 24'h0fffff;
					1: words = 24'd204800;
					default: words = 24'd409600;
				endcase
				step();
				dl_index  = (d == 0) ? DL_FLOPPY_INT : DL_FLOPPY_EXT;
				dl_active = 1'b1;
				repeat (3) step();
				end_download({words, 1'b0});
				res        = ref_floppy(words);
				exp_ins[d] = res[1];
				exp_ds[d]  = res[0];
				check_floppies();
			end
			// eject clears the double sided image
			eject[d] = 1'b1;
			step();
			eject        = 2'b00;
			exp_ins[d]   = 1'b0;
			exp_ds[d]    = 1'b0;
			check_floppies();
		end
	endtask

	task automatic run_chipset_tests();
		logic [SDRAM_AW-1:0] a;
		logic [15:0]         d;
		logic [15:0]         exp_w;
		logic                wr_check;
		int                  op;
		for (int k = 0; k < 60; k++) begin
			op       = {$random(seed)} % 3;
			wr_check = 1'b0;
			step();
			cs_addr = CS_AW'($random(seed));
			case (op)
				0: begin
					cs_rom_rd = 1'b1;
					@(negedge clk_sys);
					a = ref_rom_addr(exp_model, cs_addr);
					check_addr("sdram_addr", sdram_addr, a);
					check_flag("sdram_oe", sdram_oe, 1'b1);
					check_word("cs_rdata", cs_rdata, mem_read(a));
				end
				1: begin
					d         = 16'($random(seed));
					cs_wdata  = d;
					cs_uds    = 1'($random(seed));
					cs_lds    = 1'($random(seed));
					cs_ram_wr = 1'b1;
					@(negedge clk_sys);
					a        = ref_ram_addr(cs_addr);
					exp_w    = ref_merge(mem_read(a), d, cs_uds, cs_lds);
					wr_check = 1'b1;
					check_addr("sdram_addr", sdram_addr, a);
					check_flag("sdram_oe", sdram_oe, 1'b0);
				end
				default: begin
					cs_ram_rd  = 1'b1;
					cs_disk_rd = 1'b1;
					@(negedge clk_sys);
					a = ref_ram_addr(cs_addr);
					check_flag("sdram_oe", sdram_oe, 1'b1);
					check_word("cs_rdata", cs_rdata, ref_disk_word(mem_read(a), cs_addr[0]));
				end
			endcase
			// the write lands on this edge
			step();
			cs_rom_rd  = 1'b0;
			cs_ram_rd  = 1'b0;
			cs_ram_wr  = 1'b0;
			cs_disk_rd = 1'b0;
			if (wr_check)
				check_word($sformatf("mem[%h]", a), mem_read(a), exp_w);
		end
	endtask

	task automatic run_led_tests();
		int         cnt;
		logic [1:0] act;
		logic [1:0] prev;
		cnt  = 0;
		prev = 2'b00;
		dl_index = DL_ROM;
		for (int k = 0; k < 200; k++) begin
			step();
			// counter state after the edge that saw last cycle's pulse
			if (prev != 2'b00)
				cnt = LED_HOLD;
			else if (cnt > 0)
				cnt--;
			act        = ({$random(seed)} % 16 == 0) ? 2'($random(seed)) : 2'b00;
			disk_act   = act;
			disk_motor = (k >= 150) ? 2'b10 : 2'b00;
			dl_active  = (k >= 120 && k < 130);
			@(negedge clk_sys);
			check_flag("led", led, dl_active | ((cnt != 0) ^ (|disk_motor)));
			prev = act;
		end
		step();
		disk_act   = 2'b00;
		disk_motor = 2'b00;
		dl_active  = 1'b0;
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		seed = 32'hc172;
		checks = 0;
		errors = 0;
		timeouts = 0;
		io_reads = 0;
		rst_n = 1'b0;
		reset_req = 1'b0;
		cpu_reset_n = 1'b1;
		ram_4mb_sel = 1'b0;
		model_sel = MODEL_PLUS;
		exp_model = MODEL_PLUS;
		dl_active = 1'b0;
		dl_index = DL_ROM;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cs_addr = '0;
		cs_rom_rd = 1'b0;
		cs_ram_rd = 1'b0;
		cs_ram_wr = 1'b0;
		cs_uds = 1'b0;
		cs_lds = 1'b0;
		cs_wdata = '0;
		cs_disk_rd = 1'b0;
		eject = 2'b00;
		disk_act = 2'b00;
		disk_motor = 2'b00;
		exp_ins = 2'b00;
		exp_ds = 2'b00;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = ref_fill(25'(i));
		repeat (8) step();
		check_flag("dl_wait", dl_wait, 1'b0);
		check_flag("sys_reset_n", sys_reset_n, 1'b0);
		check_flag("sdram_we", sdram_we, 1'b0);
		rst_n = 1'b1;
		expect_release(1'b0, MODEL_PLUS);
		run_reset_tests();
		run_downloads();
		run_floppy_tests();
		run_chipset_tests();
		run_led_tests();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- design/macplus_glue_top.sv
// ========================================
// mac plus memory glue: reset, downloads,
// floppy detect and sdram sharing
// ========================================
module macplus_glue_top
	import mem_map_pkg::*;
	import mac_cfg_pkg::*;
#(
	parameter int RESET_HOLD = 16,
	parameter int SLOT_LEN   = 4,
	parameter int LED_HOLD   = 64
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	// reset and configuration
	input  logic                reset_req,
	input  logic                cpu_reset_n,
	input  logic                ram_4mb_sel,
	input  mac_model_t          model_sel,
	output logic                sys_reset_n,
	output logic                ram_4mb,
	output mac_model_t          model,
	// host download
	input  logic                dl_active,
	input  dl_index_t           dl_index,
	input  logic                dl_wr,
	input  logic [24:0]         dl_addr,
	input  logic [15:0]         dl_data,
	output logic                dl_wait,
	// chipset
	input  logic [CS_AW-1:0]    cs_addr,
	input  logic                cs_rom_rd,
	input  logic                cs_ram_rd,
	input  logic                cs_ram_wr,
	input  logic                cs_uds,
	input  logic                cs_lds,
	input  logic [SDRAM_DW-1:0] cs_wdata,
	input  logic                cs_disk_rd,
	output logic [SDRAM_DW-1:0] cs_rdata,
	// sdram
	output logic [SDRAM_AW-1:0] sdram_addr,
	output logic [SDRAM_DW-1:0] sdram_din,
	output logic [1:0]          sdram_ds,
	output logic                sdram_we,
	output logic                sdram_oe,
	input  logic [SDRAM_DW-1:0] sdram_dout,
	// floppies, bit 0 internal, bit 1 external
	input  logic [1:0]          eject,
	output logic [1:0]          floppy_ins,
	output logic [1:0]          floppy_ds,
	// disk led
	input  logic [1:0]          disk_act,
	input  logic [1:0]          disk_motor,
	output logic                led
);

	logic                io_slot;
	logic                dl_we;
	logic [DL_AW-1:0]    dl_word_addr;
	logic [SDRAM_DW-1:0] dl_wdata;

	reset_seq #(
		.RESET_HOLD(RESET_HOLD)
	) u_reset_seq (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.reset_req  (reset_req),
		.cpu_reset_n(cpu_reset_n),
		.ram_4mb_sel(ram_4mb_sel),
		.model_sel  (model_sel),
		.sys_reset_n(sys_reset_n),
		.ram_4mb    (ram_4mb),
		.model      (model)
	);

	rom_loader u_rom_loader (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_active   (dl_active),
		.io_slot     (io_slot),
		.dl_wait     (dl_wait),
		.dl_we       (dl_we),
		.dl_word_addr(dl_word_addr),
		.dl_wdata    (dl_wdata)
	);

	mem_arbiter #(
		.SLOT_LEN(SLOT_LEN)
	) u_mem_arbiter (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl_active   (dl_active),
		.dl_we       (dl_we),
		.dl_word_addr(dl_word_addr),
		.dl_wdata    (dl_wdata),
		.model       (model),
		.cs_addr     (cs_addr),
		.cs_rom_rd   (cs_rom_rd),
		.cs_ram_rd   (cs_ram_rd),
		.cs_ram_wr   (cs_ram_wr),
		.cs_uds      (cs_uds),
		.cs_lds      (cs_lds),
		.cs_wdata    (cs_wdata),
		.cs_disk_rd  (cs_disk_rd),
		.io_slot     (io_slot),
		.cs_rdata    (cs_rdata),
		.sdram_addr  (sdram_addr),
		.sdram_din   (sdram_din),
		.sdram_ds    (sdram_ds),
		.sdram_we    (sdram_we),
		.sdram_oe    (sdram_oe),
		.sdram_dout  (sdram_dout)
	);

	// internal drive
	floppy_detect #(
		.DRIVE(DL_FLOPPY_INT)
	) u_floppy_int (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.eject       (eject[0]),
		.inserted    (floppy_ins[0]),
		.double_sided(floppy_ds[0])
	);

	// external drive
	floppy_detect #(
		.DRIVE(DL_FLOPPY_EXT)
	) u_floppy_ext (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.eject       (eject[1]),
		.inserted    (floppy_ins[1]),
		.double_sided(floppy_ds[1])
	);

	disk_activity_led #(
		.LED_HOLD(LED_HOLD)
	) u_disk_led (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.disk_act  (disk_act),
		.disk_motor(disk_motor),
		.dl_active (dl_active),
		.led       (led)
	);

endmodule

//--- design/disk_activity_led.sv
// ========================================
// disk led: stretches activity pulses into
// a visible level
// ========================================
module disk_activity_led #(
	parameter int LED_HOLD = 64
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [1:0] disk_act,
	input  logic [1:0] disk_motor,
	input  logic       dl_active,
	output logic       led
);

	localparam int CW = $clog2(LED_HOLD + 1);

	logic [CW-1:0] hold_cnt;
	logic          act_stretch;

	// any drive pulse restarts the hold window
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hold_cnt <= '0;
		end else if (|disk_act) begin
			hold_cnt <= CW'(LED_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign act_stretch = (hold_cnt != '0);

	// motor on gives steady light, activity blinks it off
	assign led = dl_active || (act_stretch ^ (|disk_motor));

endmodule

//--- memory/mem_arbiter.sv
// ========================================
// memory arbiter: bus slot sequence and the
// shared sdram port, loader vs chipset
// ========================================
module mem_arbiter
	import mem_map_pkg::*;
	import mac_cfg_pkg::*;
#(
	parameter int SLOT_LEN = 4
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	// loader side
	input  logic                dl_active,
	input  logic                dl_we,
	input  logic [DL_AW-1:0]    dl_word_addr,
	input  logic [SDRAM_DW-1:0] dl_wdata,
	input  mac_model_t          model,
	// chipset side
	input  logic [CS_AW-1:0]    cs_addr,
	input  logic                cs_rom_rd,
	input  logic                cs_ram_rd,
	input  logic                cs_ram_wr,
	input  logic                cs_uds,
	input  logic                cs_lds,
	input  logic [SDRAM_DW-1:0] cs_wdata,
	input  logic                cs_disk_rd,
	output logic                io_slot,
	output logic [SDRAM_DW-1:0] cs_rdata,
	// sdram port
	output logic [SDRAM_AW-1:0] sdram_addr,
	output logic [SDRAM_DW-1:0] sdram_din,
	output logic [1:0]          sdram_ds,
	output logic                sdram_we,
	output logic                sdram_oe,
	input  logic [SDRAM_DW-1:0] sdram_dout
);

	localparam int CW = (SLOT_LEN > 1) ? $clog2(SLOT_LEN) : 1;

	bus_slot_t              slot;
	logic [CW-1:0]          slot_cnt;
	logic                   dl_cycle;
	logic [SDRAM_AW-1:0]    cs_map;
	logic [7:0]             disk_byte;

	// ========================================
	// slot sequence
	// ========================================

	// video, cpu, io, cpu, each SLOT_LEN clocks
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			slot     <= SLOT_VIDEO;
			slot_cnt <= '0;
		end else if (slot_cnt == CW'(SLOT_LEN - 1)) begin
			slot_cnt <= '0;
			// 2 bit wrap brings cpu_b back to video
			slot     <= bus_slot_t'(slot + 2'd1);
		end else begin
			slot_cnt <= slot_cnt + 1'b1;
		end
	end

	assign io_slot = (slot == SLOT_IO);

	// loader owns the port in io slots of a running download
	assign dl_cycle = dl_active && io_slot;

	// ========================================
	// chipset address map
	// ========================================

	// rom: model bit stands in for address bits 21:19
	// ram: plain word address in the low region
	always_comb begin
		if (cs_rom_rd) begin
			cs_map = {ROM_REGION, 2'b00, model, cs_addr[18:1]};
		end else begin
			cs_map = {4'b0000, cs_addr[21:1]};
		end
	end

	// ========================================
	// port mux
	// ========================================

	assign sdram_addr = dl_cycle ? {DL_REGION, dl_word_addr} : cs_map;
	assign sdram_din  = dl_cycle ? dl_wdata : cs_wdata;
	assign sdram_ds   = dl_cycle ? 2'b11 : {cs_uds, cs_lds};
	assign sdram_we   = dl_cycle ? dl_we : cs_ram_wr;
	assign sdram_oe   = dl_cycle ? 1'b0 : (cs_rom_rd || cs_ram_rd);

	// ========================================
	// read data
	// ========================================

	// disk images are byte wide, addr bit 0 picks the low byte
	assign disk_byte = cs_addr[0] ? sdram_dout[7:0] : sdram_dout[15:8];

	// all ones while downloading keeps the screen black
	always_comb begin
		if (dl_cycle) begin
			cs_rdata = '1;
		end else if (cs_disk_rd) begin
			cs_rdata = {disk_byte, disk_byte};
		end else begin
			cs_rdata = sdram_dout;
		end
	end

	// a write and a read at once would corrupt the model's bus
	a_we_oe_excl: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		!(sdram_we && sdram_oe)
	);

endmodule

//--- loader/floppy_detect.sv
// ========================================
// floppy detect: image presence and sides
// for one drive, from the download size
// ========================================
module floppy_detect
	import mac_cfg_pkg::*;
#(
	parameter dl_index_t DRIVE = DL_FLOPPY_INT
) (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        dl_active,
	input  dl_index_t   dl_index,
	input  logic [24:0] dl_addr,
	input  logic        eject,
	output logic        inserted,
	output logic        double_sided
);

	logic        active_d;
	logic        ss_flag;
	logic [23:0] word_cnt;

	// address after the last write equals the word count
	assign word_cnt = dl_addr[24:1];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			active_d     <= 1'b0;
			double_sided <= 1'b0;
			ss_flag      <= 1'b0;
		end else begin
			active_d <= dl_active;
			// end of a download for this drive
			if (active_d && !dl_active && dl_index == DRIVE) begin
				double_sided <= (word_cnt == IMG_WORDS_DS);
				ss_flag      <= (word_cnt == IMG_WORDS_SS);
			end
			// eject from the os wins
			if (eject) begin
				double_sided <= 1'b0;
				ss_flag      <= 1'b0;
			end
		end
	end

	// odd sizes leave the drive empty
	assign inserted = double_sided || ss_flag;

endmodule

//--- loader/rom_loader.sv
// ========================================
// rom loader: host download words to
// slot timed sdram writes with host wait
// ========================================
module rom_loader
	import mem_map_pkg::*;
	import mac_cfg_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                dl_wr,
	input  dl_index_t           dl_index,
	input  logic [24:0]         dl_addr,
	input  logic [15:0]         dl_data,
	input  logic                dl_active,
	input  logic                io_slot,
	output logic                dl_wait,
	output logic                dl_we,
	output logic [DL_AW-1:0]    dl_word_addr,
	output logic [SDRAM_DW-1:0] dl_wdata
);

	logic             wr_pend;
	logic             io_slot_d;
	logic [DL_AW-1:0] map_addr;

	// ========================================
	// address mapping
	// ========================================

	// floppies: index low bits select a 512k word window
	// rom: index bit 6 selects plus or se image, 256k words each
	always_comb begin
		if (dl_index[1:0] != 2'b00) begin
			map_addr = {dl_index[1:0], dl_addr[19:1]};
		end else begin
			map_addr = {2'b00, dl_index[6], dl_addr[18:1]};
		end
	end

	// ========================================
	// capture
	// ========================================

	// host sends little endian words, 68k wants big endian
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			dl_wdata     <= {dl_data[7:0], dl_data[15:8]};
			dl_word_addr <= map_addr;
		end
	end

	// ========================================
	// wait and pending write
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_wait   <= 1'b0;
			wr_pend   <= 1'b0;
			io_slot_d <= 1'b0;
		end else begin
			// hold the host off until the word is in sdram
			if (dl_wr) begin
				dl_wait <= 1'b1;
			end
			io_slot_d <= io_slot;
			// arm the write only outside the io slot
			// so it covers one whole slot
			if (!io_slot) begin
				wr_pend <= dl_wait;
			end
			// end of the io slot with a write done
			if (io_slot_d && !io_slot && wr_pend) begin
				dl_wait <= 1'b0;
			end
		end
	end

	// write enable only counts while the download is open
	assign dl_we = wr_pend && dl_active;

	// host must honour the wait level
	a_no_wr_in_wait: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		dl_wait |-> !dl_wr
	);

endmodule

//--- design/reset_seq.sv
// ========================================
// reset sequencer: stretches reset and
// latches the machine configuration
// ========================================
module reset_seq
	import mac_cfg_pkg::*;
#(
	parameter int RESET_HOLD = 16
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       reset_req,
	input  logic       cpu_reset_n,
	input  logic       ram_4mb_sel,
	input  mac_model_t model_sel,
	output logic       sys_reset_n,
	output logic       ram_4mb,
	output mac_model_t model
);

	localparam int CW = $clog2(RESET_HOLD + 1);

	logic [CW-1:0] hold_cnt;
	logic          any_src;

	// board reset, user request or the cpu reset instruction
	assign any_src = !rst_n || reset_req || !cpu_reset_n;

	// ========================================
	// hold counter
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (any_src) begin
			// restart the hold window on every active cycle
			hold_cnt    <= CW'(RESET_HOLD);
			sys_reset_n <= 1'b0;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
			// selections follow the host until the count ends
			ram_4mb  <= ram_4mb_sel;
			model    <= model_sel;
		end else begin
			sys_reset_n <= 1'b1;
		end
	end

	// the running machine must never see its memory size or rom move
	a_cfg_frozen: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		sys_reset_n |=> ($stable(ram_4mb) && $stable(model))
	);

endmodule

//--- common/mac_cfg_pkg.sv
// ========================================
// machine configuration: download indexes,
// floppy image sizes and model select
// ========================================
package mac_cfg_pkg;

	// ========================================
	// host download index
	// ========================================

	// floppy indexes use their low bits as image slot
	// rom index may carry bit 6 to pick the se image
	typedef enum logic [7:0] {
		DL_ROM        = 8'd0,
		DL_FLOPPY_INT = 8'd1,
		DL_FLOPPY_EXT = 8'd2
	} dl_index_t;

	// ========================================
	// floppy image sizes in 16 bit words
	// ========================================

	// 800k double sided image
	localparam logic [23:0] IMG_WORDS_DS = 24'd409600;

	// 400k single sided image
	localparam logic [23:0] IMG_WORDS_SS = 24'd204800;

	// ========================================
	// machine model
	// ========================================

	// also used as the rom image select bit
	typedef enum logic {
		MODEL_PLUS = 1'b0,
		MODEL_SE   = 1'b1
	} mac_model_t;

endpackage

//--- common/mem_map_pkg.sv
// ========================================
// memory map: sdram widths, region prefixes
// and the bus slot sequence
// ========================================
package mem_map_pkg;

	// ========================================
	// port widths
	// ========================================

	// sdram word address, 32M words of 16 bit
	localparam int SDRAM_AW = 25;
	localparam int SDRAM_DW = 16;

	// chipset word address
	// bit 0 picks the byte on disk image reads
	localparam int CS_AW = 22;

	// loader word address inside the download window
	localparam int DL_AW = 21;

	// ========================================
	// region prefixes, top 4 bits of sdram_addr
	// ========================================

	// downloads land at word 0x200000 and up
	localparam logic [3:0] DL_REGION = 4'b0001;

	// rom reads hit the same window as the rom download
	// (index 0, model bit selects the image)
	localparam logic [3:0] ROM_REGION = 4'b0001;

	// ========================================
	// bus slots
	// ========================================

	// four slots per round, io slot belongs to the loader
	// while a download runs
	typedef enum logic [1:0] {
		SLOT_VIDEO = 2'd0,
		SLOT_CPU_A = 2'd1,
		SLOT_IO    = 2'd2,
		SLOT_CPU_B = 2'd3
	} bus_slot_t;

endpackage
